// File: hdl/core_pkg.sv
package core_pkg;

  typedef logic [31:0] word_t;      // data word, address or instruction
  typedef logic [3:0]  reg_addr_t;  // x0..x15
  typedef logic [3:0]  byte_mask_t;
  typedef logic [1:0]  mem_size_t;

  localparam mem_size_t size_byte = 2'd0;
  localparam mem_size_t size_half = 2'd1;
  localparam mem_size_t size_word = 2'd2;

  typedef enum logic [4:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_slt,
    op_sltu,
    op_sll,
    op_srl,
    op_sra,
    op_lui,    // pass immediate
    op_auipc,  // pc + immediate
    op_link,   // jal / jalr
    op_addr,   // load/store address
    op_beq,
    op_bne,
    op_blt,
    op_bge,
    op_bltu,
    op_bgeu
  } alu_op_e;

  typedef enum logic [1:0] {
    ld_lw,
    ld_lbu,
    ld_lh,
    ld_lhu
  } load_kind_e;

endpackage

// File: hdl/instr_sequencer.sv
`timescale 1ns/1ns

module instr_sequencer #(
  parameter core_pkg::word_t reset_vector = 32'h3000_0000
) (
  input  logic            clock,
  input  logic            reset,
  input  core_pkg::word_t ifu_rdata,
  input  logic            ifu_resp,
  input  logic            is_mem,
  input  logic            mem_done,
  input  core_pkg::word_t next_pc,
  output core_pkg::word_t ifu_addr,
  output logic            ifu_req,
  output core_pkg::word_t instr,
  output core_pkg::word_t pc,
  output logic            mem_start,
  output logic            commit
);
  import core_pkg::*;

  typedef enum logic [1:0] {
    fetch_req,
    fetch_wait,
    execute,
    mem_wait
  } seq_state_e;

  seq_state_e state;

  assign ifu_addr  = pc;  // held until ifu_resp
  assign mem_start = (state == execute) && is_mem;
  assign commit    = ((state == execute) && !is_mem) || ((state == mem_wait) && mem_done);

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= fetch_req;
      ifu_req <= 1'b0;
      pc      <= reset_vector;
    end else begin
      if (commit) begin
        pc <= next_pc;
      end
      case (state)
        fetch_req: begin
          // only low here right after reset, raise it first
          ifu_req <= !ifu_req;
          if (ifu_req) begin
            state <= fetch_wait;
          end
        end
        fetch_wait: begin
          if (ifu_resp) begin
            state <= execute;
          end
        end
        execute: begin
          if (is_mem) begin
            state <= mem_wait;
          end else begin
            state   <= fetch_req;
            ifu_req <= 1'b1;  // next fetch from next_pc
          end
        end
        default: begin
          if (mem_done) begin
            state   <= fetch_req;
            ifu_req <= 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == fetch_wait && ifu_resp) begin
      instr <= ifu_rdata;
    end
  end

  a_ifu_req_pulse: assert property (@(posedge clock) disable iff (reset)
    ifu_req |=> !ifu_req);

endmodule

// File: hdl/instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder (
  input  core_pkg::word_t      instr,
  output core_pkg::reg_addr_t  rs1,
  output core_pkg::reg_addr_t  rs2,
  output core_pkg::reg_addr_t  rd,
  output core_pkg::word_t      imm,
  output core_pkg::alu_op_e    alu_op,
  output logic                 use_imm,
  output logic                 reg_write,
  output logic                 is_mem,
  output logic                 is_store,
  output logic                 is_jalr,
  output logic                 is_branch,
  output core_pkg::load_kind_e load_kind,
  output core_pkg::mem_size_t  store_size
);
  import core_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign rs1    = instr[18:15];  // rv32e, upper index bit ignored
  assign rs2    = instr[23:20];
  assign rd     = instr[10:7];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    imm        = imm_i;
    alu_op     = op_add;
    use_imm    = 1'b0;
    reg_write  = 1'b0;
    is_mem     = 1'b0;
    is_store   = 1'b0;
    is_jalr    = 1'b0;
    is_branch  = 1'b0;
    load_kind  = ld_lw;
    store_size = size_word;
    case (opcode)
      7'b0110011, 7'b0010011: begin
        use_imm   = !opcode[5];  // op-imm form
        reg_write = 1'b1;
        case (funct3)
          3'b000:  alu_op = (opcode[5] && instr[30]) ? op_sub : op_add;
          3'b001:  alu_op = op_sll;
          3'b010:  alu_op = op_slt;
          3'b011:  alu_op = op_sltu;
          3'b100:  alu_op = op_xor;
          3'b101:  alu_op = instr[30] ? op_sra : op_srl;
          3'b110:  alu_op = op_or;
          default: alu_op = op_and;
        endcase
      end
      7'b0110111: begin
        imm       = imm_u;
        alu_op    = op_lui;
        reg_write = 1'b1;
      end
      7'b0010111: begin
        imm       = imm_u;
        alu_op    = op_auipc;
        reg_write = 1'b1;
      end
      7'b1101111: begin
        // jal is handled as an always-taken branch
        imm       = imm_j;
        alu_op    = op_link;
        reg_write = 1'b1;
        is_branch = 1'b1;
      end
      7'b1100111: begin
        if (funct3 == 3'b000) begin
          alu_op    = op_link;
          use_imm   = 1'b1;  // rs1 + imm target
          reg_write = 1'b1;
          is_jalr   = 1'b1;
        end
      end
      7'b1100011: begin
        imm       = imm_b;
        is_branch = 1'b1;
        case (funct3)
          3'b000:  alu_op = op_beq;
          3'b001:  alu_op = op_bne;
          3'b100:  alu_op = op_blt;
          3'b101:  alu_op = op_bge;
          3'b110:  alu_op = op_bltu;
          3'b111:  alu_op = op_bgeu;
          default: is_branch = 1'b0;
        endcase
      end
      7'b0000011: begin
        alu_op    = op_addr;
        use_imm   = 1'b1;
        is_mem    = 1'b1;
        reg_write = 1'b1;
        case (funct3)
          3'b010: load_kind = ld_lw;
          3'b100: load_kind = ld_lbu;
          3'b001: load_kind = ld_lh;
          3'b101: load_kind = ld_lhu;
          default: begin
            is_mem    = 1'b0;  // lb and others not supported
            reg_write = 1'b0;
          end
        endcase
      end
      7'b0100011: begin
        imm      = imm_s;
        alu_op   = op_addr;
        use_imm  = 1'b1;
        is_mem   = 1'b1;
        is_store = 1'b1;
        case (funct3)
          3'b000: store_size = size_byte;
          3'b001: store_size = size_half;
          3'b010: store_size = size_word;
          default: begin
            is_mem   = 1'b0;
            is_store = 1'b0;
          end
        endcase
      end
      default: ;  // unknown opcode, no effect
    endcase
  end

endmodule

// File: hdl/register_file.sv
`timescale 1ns/1ns

module register_file (
  input  logic                clock,
  input  core_pkg::reg_addr_t rs1,
  input  core_pkg::reg_addr_t rs2,
  input  core_pkg::reg_addr_t rd,
  input  core_pkg::word_t     rd_data,
  input  logic                wen,
  output core_pkg::word_t     rs1_data,
  output core_pkg::word_t     rs2_data
);
  import core_pkg::*;

  word_t regs [16];

  always_ff @(posedge clock) begin
    if (wen && rd != '0) begin
      regs[rd] <= rd_data;
    end
    regs[0] <= '0;  // x0 entry held at zero
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  a_x0_zero: assert property (@(posedge clock)
    (rs1 == '0) |-> (rs1_data == '0));

endmodule

// File: hdl/execute_unit.sv
`timescale 1ns/1ns

module execute_unit (
  input  core_pkg::word_t   pc,
  input  core_pkg::word_t   rs1_data,
  input  core_pkg::word_t   rs2_data,
  input  core_pkg::word_t   imm,
  input  core_pkg::alu_op_e alu_op,
  input  logic              use_imm,
  output core_pkg::word_t   alu_result,
  output logic              branch_taken,
  output core_pkg::word_t   target
);
  import core_pkg::*;

  word_t op_b;
  word_t sum;
  logic  is_eq;
  logic  lt_signed;
  logic  lt_unsigned;

  assign op_b        = use_imm ? imm : rs2_data;
  assign sum         = rs1_data + op_b;
  assign is_eq       = (rs1_data == op_b);
  assign lt_signed   = $signed(rs1_data) < $signed(op_b);
  assign lt_unsigned = rs1_data < op_b;

  // jalr is the only link op with an immediate operand
  assign target = (alu_op == op_link && use_imm) ? {sum[31:1], 1'b0} : pc + imm;

  always_comb begin
    case (alu_op)
      op_sub:   alu_result = rs1_data - op_b;
      op_and:   alu_result = rs1_data & op_b;
      op_or:    alu_result = rs1_data | op_b;
      op_xor:   alu_result = rs1_data ^ op_b;
      op_slt:   alu_result = {31'b0, lt_signed};
      op_sltu:  alu_result = {31'b0, lt_unsigned};
      op_sll:   alu_result = rs1_data << op_b[4:0];
      op_srl:   alu_result = rs1_data >> op_b[4:0];
      op_sra:   alu_result = $signed(rs1_data) >>> op_b[4:0];
      op_lui:   alu_result = imm;
      op_auipc: alu_result = pc + imm;
      default:  alu_result = sum;  // add, link, address
    endcase
  end

  always_comb begin
    case (alu_op)
      op_beq:  branch_taken = is_eq;
      op_bne:  branch_taken = !is_eq;
      op_blt:  branch_taken = lt_signed;
      op_bge:  branch_taken = !lt_signed;
      op_bltu: branch_taken = lt_unsigned;
      op_bgeu: branch_taken = !lt_unsigned;
      op_link: branch_taken = 1'b1;
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

// File: hdl/load_store_unit.sv
`timescale 1ns/1ns

module load_store_unit (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 mem_start,
  input  core_pkg::word_t      alu_result,
  input  core_pkg::word_t      rs2_data,
  input  logic                 is_store,
  input  core_pkg::mem_size_t  store_size,
  input  core_pkg::load_kind_e load_kind,
  input  core_pkg::word_t      lsu_rdata,
  input  logic                 lsu_resp,
  output core_pkg::word_t      lsu_addr,
  output logic                 lsu_req,
  output logic                 lsu_wen,
  output core_pkg::mem_size_t  lsu_size,
  output core_pkg::word_t      lsu_wdata,
  output core_pkg::byte_mask_t lsu_wmask,
  output logic                 mem_done,
  output core_pkg::word_t      load_data
);
  import core_pkg::*;

  typedef enum logic {
    lsu_idle,
    lsu_wait
  } lsu_state_e;

  lsu_state_e  state;
  logic [1:0]  lane;
  logic [7:0]  rd_byte;
  logic [15:0] rd_half;
  mem_size_t   load_size;

  // operands come from the held instruction, stable until commit
  assign lane     = alu_result[1:0];
  assign lsu_addr = alu_result;
  assign lsu_wen  = lsu_req && is_store;
  assign lsu_size = is_store ? store_size : load_size;
  assign mem_done = (state == lsu_wait) && lsu_resp;

  always_comb begin
    case (load_kind)
      ld_lbu:        load_size = size_byte;
      ld_lh, ld_lhu: load_size = size_half;
      default:       load_size = size_word;
    endcase
  end

  always_comb begin
    lsu_wdata = rs2_data;
    lsu_wmask = '0;  // loads
    if (is_store) begin
      case (store_size)
        size_byte: begin
          lsu_wdata = word_t'(rs2_data[7:0]) << {lane, 3'b000};
          lsu_wmask = 4'b0001 << lane;
        end
        size_half: begin
          lsu_wdata = word_t'(rs2_data[15:0]) << {lane[1], 4'b0000};
          lsu_wmask = lane[1] ? 4'b1100 : 4'b0011;
        end
        default: lsu_wmask = 4'b1111;
      endcase
    end
  end

  assign rd_byte = lsu_rdata[{lane, 3'b000} +: 8];
  assign rd_half = lane[1] ? lsu_rdata[31:16] : lsu_rdata[15:0];

  always_comb begin
    case (load_kind)
      ld_lbu:  load_data = {24'b0, rd_byte};
      ld_lh:   load_data = {{16{rd_half[15]}}, rd_half};
      ld_lhu:  load_data = {16'b0, rd_half};
      default: load_data = lsu_rdata;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= lsu_idle;
      lsu_req <= 1'b0;
    end else begin
      lsu_req <= 1'b0;  // single-cycle request
      case (state)
        lsu_idle: begin
          if (mem_start) begin
            lsu_req <= 1'b1;
            state   <= lsu_wait;
          end
        end
        default: begin
          if (lsu_resp) begin
            state <= lsu_idle;
          end
        end
      endcase
    end
  end

  // a new access only starts once the previous one has answered
  a_no_overlap: assert property (@(posedge clock) disable iff (reset)
    mem_start |-> (state == lsu_idle));

endmodule

// File: hdl/writeback_select.sv
`timescale 1ns/1ns

module writeback_select (
  input  core_pkg::word_t   pc,
  input  core_pkg::word_t   alu_result,
  input  core_pkg::word_t   load_data,
  input  logic              branch_taken,
  input  core_pkg::word_t   target,
  input  logic              is_branch,
  input  logic              is_jalr,
  input  core_pkg::alu_op_e alu_op,
  input  logic              is_mem,
  input  logic              is_store,
  input  logic              reg_write,
  input  logic              commit,
  output core_pkg::word_t   rd_data,
  output logic              rd_wen,
  output core_pkg::word_t   next_pc
);
  import core_pkg::*;

  word_t pc_plus4;
  logic  redirect;

  assign pc_plus4 = pc + 32'd4;
  assign redirect = (is_branch && branch_taken) || is_jalr;  // jal counts as a branch

  assign rd_data = (alu_op == op_link)    ? pc_plus4 :
                   (is_mem && !is_store)  ? load_data :
                                            alu_result;

  assign next_pc = redirect ? target : pc_plus4;
  assign rd_wen  = commit && reg_write;

endmodule

// File: hdl/rv_core_top.sv
`timescale 1ns/1ns

module rv_core_top #(
  parameter core_pkg::word_t reset_vector = 32'h3000_0000
) (
  input  logic                 clock,
  input  logic                 reset,
  output core_pkg::word_t      ifu_addr,
  output logic                 ifu_req,
  input  core_pkg::word_t      ifu_rdata,
  input  logic                 ifu_resp,
  output core_pkg::word_t      lsu_addr,
  output logic                 lsu_req,
  input  core_pkg::word_t      lsu_rdata,
  input  logic                 lsu_resp,
  output logic                 lsu_wen,
  output core_pkg::mem_size_t  lsu_size,
  output core_pkg::word_t      lsu_wdata,
  output core_pkg::byte_mask_t lsu_wmask
);
  import core_pkg::*;

  word_t      instr;
  word_t      pc;
  word_t      next_pc;
  word_t      imm;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      alu_result;
  word_t      target;
  word_t      load_data;
  word_t      rd_data;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  reg_addr_t  rd;
  alu_op_e    alu_op;
  load_kind_e load_kind;
  mem_size_t  store_size;
  logic       use_imm;
  logic       reg_write;
  logic       is_mem;
  logic       is_store;
  logic       is_jalr;
  logic       is_branch;
  logic       branch_taken;
  logic       mem_start;
  logic       mem_done;
  logic       commit;
  logic       rd_wen;

  instr_sequencer #(
    .reset_vector(reset_vector)
  ) sequencer0 (
    .clock(clock),
    .reset(reset),
    .ifu_rdata(ifu_rdata),
    .ifu_resp(ifu_resp),
    .is_mem(is_mem),
    .mem_done(mem_done),
    .next_pc(next_pc),
    .ifu_addr(ifu_addr),
    .ifu_req(ifu_req),
    .instr(instr),
    .pc(pc),
    .mem_start(mem_start),
    .commit(commit)
  );

  instr_decoder decoder0 (
    .instr(instr),
    .rs1(rs1),
    .rs2(rs2),
    .rd(rd),
    .imm(imm),
    .alu_op(alu_op),
    .use_imm(use_imm),
    .reg_write(reg_write),
    .is_mem(is_mem),
    .is_store(is_store),
    .is_jalr(is_jalr),
    .is_branch(is_branch),
    .load_kind(load_kind),
    .store_size(store_size)
  );

  register_file regs0 (
    .clock(clock),
    .rs1(rs1),
    .rs2(rs2),
    .rd(rd),
    .rd_data(rd_data),
    .wen(rd_wen),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  execute_unit exec0 (
    .pc(pc),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .imm(imm),
    .alu_op(alu_op),
    .use_imm(use_imm),
    .alu_result(alu_result),
    .branch_taken(branch_taken),
    .target(target)
  );

  load_store_unit lsu0 (
    .clock(clock),
    .reset(reset),
    .mem_start(mem_start),
    .alu_result(alu_result),
    .rs2_data(rs2_data),
    .is_store(is_store),
    .store_size(store_size),
    .load_kind(load_kind),
    .lsu_rdata(lsu_rdata),
    .lsu_resp(lsu_resp),
    .lsu_addr(lsu_addr),
    .lsu_req(lsu_req),
    .lsu_wen(lsu_wen),
    .lsu_size(lsu_size),
    .lsu_wdata(lsu_wdata),
    .lsu_wmask(lsu_wmask),
    .mem_done(mem_done),
    .load_data(load_data)
  );

  writeback_select wb0 (
    .pc(pc),
    .alu_result(alu_result),
    .load_data(load_data),
    .branch_taken(branch_taken),
    .target(target),
    .is_branch(is_branch),
    .is_jalr(is_jalr),
    .alu_op(alu_op),
    .is_mem(is_mem),
    .is_store(is_store),
    .reg_write(reg_write),
    .commit(commit),
    .rd_data(rd_data),
    .rd_wen(rd_wen),
    .next_pc(next_pc)
  );

endmodule

// File: tb/clock_gen.sv
`timescale 1ns/1ns

module clock_gen #(
  parameter int period       = 4,
  parameter int reset_cycles = 16
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clock);
    #1 reset = 1'b0;  // released just after the edge
  end

endmodule

// File: tb/mem_model.sv
`timescale 1ns/1ns

module mem_model #(
  parameter core_pkg::word_t base  = 32'h3000_0000,
  parameter int              depth = 512
) (
  input  logic                 clock,
  input  logic                 reset,
  input  core_pkg::word_t      ifu_addr,
  input  logic                 ifu_req,
  output core_pkg::word_t      ifu_rdata,
  output logic                 ifu_resp,
  input  core_pkg::word_t      lsu_addr,
  input  logic                 lsu_req,
  output core_pkg::word_t      lsu_rdata,
  output logic                 lsu_resp,
  input  logic                 lsu_wen,
  input  core_pkg::word_t      lsu_wdata,
  input  core_pkg::byte_mask_t lsu_wmask
);
  import core_pkg::*;

  word_t  mem [depth];
  integer seed;
  int     ifu_count;
  int     lsu_count;
  logic   ifu_busy;
  logic   lsu_busy;

  function automatic int word_index(input word_t addr);
    word_t offset;
    offset = (addr - base) >> 2;
    return int'(offset % word_t'(depth));
  endfunction

  task automatic load_word(input word_t addr, input word_t data);
    mem[word_index(addr)] = data;
  endtask

  initial begin
    seed      = 96787;
    ifu_resp  = 1'b0;
    lsu_resp  = 1'b0;
    ifu_rdata = '0;
    lsu_rdata = '0;
    ifu_busy  = 1'b0;
    lsu_busy  = 1'b0;
    ifu_count = 0;
    lsu_count = 0;
    for (int i = 0; i < depth; i++) begin
      mem[i] = (base + word_t'(i * 4)) ^ 32'h5a5a_a5a5;  // unwritten words differ per address
    end
  end

  always @(posedge clock) begin
    logic ifu_seen;
    logic lsu_seen;
    logic store_seen;
    int   idx;
    ifu_seen   = ifu_req;  // values from the cycle that just ended
    lsu_seen   = lsu_req;
    store_seen = lsu_wen;
    #1;
    ifu_resp = 1'b0;
    lsu_resp = 1'b0;
    if (reset) begin
      ifu_busy = 1'b0;
      lsu_busy = 1'b0;
    end else begin
      if (ifu_seen) begin
        ifu_busy  = 1'b1;
        ifu_count = 1 + int'($unsigned($random(seed)) % 4);
      end
      if (ifu_busy) begin
        ifu_count = ifu_count - 1;
        if (ifu_count == 0) begin
          ifu_resp  = 1'b1;
          ifu_rdata = mem[word_index(ifu_addr)];
          ifu_busy  = 1'b0;
        end
      end
      if (lsu_seen) begin
        lsu_busy  = 1'b1;
        lsu_count = 1 + int'($unsigned($random(seed)) % 4);
        if (store_seen) begin
          idx = word_index(lsu_addr);
          for (int b = 0; b < 4; b++) begin
            if (lsu_wmask[b]) begin
              mem[idx][8*b +: 8] = lsu_wdata[8*b +: 8];
            end
          end
        end
      end
      if (lsu_busy) begin
        lsu_count = lsu_count - 1;
        if (lsu_count == 0) begin
          lsu_resp  = 1'b1;
          lsu_rdata = mem[word_index(lsu_addr)];
          lsu_busy  = 1'b0;
        end
      end
    end
  end

endmodule

// File: tb/core_tb.sv
`timescale 1ns/1ns

module core_tb;
  import core_pkg::*;

  localparam word_t reset_vector = 32'h3000_0000;
  localparam int    clock_period = 4;

  logic       clock;
  logic       reset;
  word_t      ifu_addr;
  logic       ifu_req;
  word_t      ifu_rdata;
  logic       ifu_resp;
  word_t      lsu_addr;
  logic       lsu_req;
  word_t      lsu_rdata;
  logic       lsu_resp;
  logic       lsu_wen;
  mem_size_t  lsu_size;
  word_t      lsu_wdata;
  byte_mask_t lsu_wmask;

  word_t      exp_addr [$];
  word_t      exp_data [$];
  byte_mask_t exp_mask [$];
  string      exp_name [$];
  int         program_words = 0;
  int         store_index = 0;
  int         cycles = 0;
  bit         program_loaded = 0;
  bit         first_fetch_seen = 0;

  clock_gen #(.period(clock_period), .reset_cycles(16)) clk0 (.clock(clock), .reset(reset));

  mem_model mem0 (
    .clock(clock), .reset(reset),
    .ifu_addr(ifu_addr), .ifu_req(ifu_req), .ifu_rdata(ifu_rdata), .ifu_resp(ifu_resp),
    .lsu_addr(lsu_addr), .lsu_req(lsu_req), .lsu_rdata(lsu_rdata), .lsu_resp(lsu_resp),
    .lsu_wen(lsu_wen), .lsu_wdata(lsu_wdata), .lsu_wmask(lsu_wmask)
  );

  rv_core_top dut0 (
    .clock(clock), .reset(reset),
    .ifu_addr(ifu_addr), .ifu_req(ifu_req), .ifu_rdata(ifu_rdata), .ifu_resp(ifu_resp),
    .lsu_addr(lsu_addr), .lsu_req(lsu_req), .lsu_rdata(lsu_rdata), .lsu_resp(lsu_resp),
    .lsu_wen(lsu_wen), .lsu_size(lsu_size), .lsu_wdata(lsu_wdata), .lsu_wmask(lsu_wmask)
  );

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("Mismatch %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_mask(input string name, input byte_mask_t expected,
                            input byte_mask_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("Mismatch %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_size(input string name, input mem_size_t expected,
                            input mem_size_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("Mismatch %s expected %0d actual %0d", name, expected, actual));
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      report_failure($sformatf("Mismatch %s expected %b actual %b", name, expected, actual));
    end
  endtask

  // byte, halfword or word access as given by the store mask
  function automatic mem_size_t size_for_mask(input byte_mask_t mask);
    case (mask)
      4'b1111:          return size_word;
      4'b0011, 4'b1100: return size_half;
      default:          return size_byte;
    endcase
  endfunction

  // m lines go into memory, s lines are the expected store trace
  task automatic load_program();
    int         fd;
    int         code;
    string      line;
    string      kind;
    string      name;
    word_t      addr;
    word_t      data;
    byte_mask_t mask;
    fd = $fopen("tb/program_input.txt", "r");
    if (fd == 0) begin
      report_failure("could not open tb/program_input.txt");
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line[0] != "#") begin
        code = $sscanf(line, "%s %h %h %h %s", kind, addr, data, mask, name);
        if (kind == "m") begin
          mem0.load_word(addr, data);
          program_words++;
        end else if (kind == "s") begin
          exp_addr.push_back(addr);
          exp_data.push_back(data);
          exp_mask.push_back(mask);
          exp_name.push_back(name);
        end
      end
    end
    $fclose(fd);
    if (program_words == 0 || exp_addr.size() == 0) begin
      report_failure("data file holds no program or no expected stores");
    end
  endtask

  task automatic check_store();
    string name;
    if (store_index >= exp_addr.size()) begin
      report_failure($sformatf("store to %h after the end of the expected trace", lsu_addr));
    end
    name = exp_name[store_index];
    check_word({name, " addr"}, exp_addr[store_index], lsu_addr);
    check_word({name, " data"}, exp_data[store_index], lsu_wdata);
    check_mask({name, " mask"}, exp_mask[store_index], lsu_wmask);
    check_size({name, " size"}, size_for_mask(exp_mask[store_index]), lsu_size);
    store_index++;
    if (store_index == exp_addr.size()) begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  endtask

  initial begin
    @(posedge clock);  // after the memory fill at time zero
    load_program();
    program_loaded = 1;
  end

  initial begin : watchdog
    wait (program_loaded);
    #((program_words * 64 + 16) * clock_period);  // worst-case latency per word
    report_failure($sformatf("program did not finish, %0d of %0d stores seen",
                             store_index, exp_addr.size()));
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (!reset) begin
      if (ifu_req && !first_fetch_seen) begin
        first_fetch_seen = 1;
        check_word("first fetch addr", reset_vector, ifu_addr);
      end
      if (lsu_req && !lsu_wen) begin
        check_mask("load mask", 4'b0000, lsu_wmask);
      end
      if (lsu_wen) begin
        check_store();
      end
    end
  end

  // outputs settle after the first reset edge
  always @(negedge clock) begin
    if (reset && cycles > 0) begin
      check_bit("reset ifu_req", 1'b0, ifu_req);
      check_bit("reset lsu_req", 1'b0, lsu_req);
      check_bit("reset lsu_wen", 1'b0, lsu_wen);
    end
  end

endmodule

// File: tb/program_input.txt
# m <word address> <instruction>
# s <store address> <write data> <byte mask> <test name>
m 30000000 30000137
m 30000004 40010113
m 30000008 ff900193
m 3000000c 06400213
m 30000010 004182b3
m 30000014 00512023
m 30000018 40418333
m 3000001c 00612223
m 30000020 0041c3b3
m 30000024 00712423
m 30000028 0041e433
m 3000002c 0f01f493
m 30000030 00812623
m 30000034 00912823
m 30000038 0041a533
m 3000003c 0041b5b3
m 30000040 00a12a23
m 30000044 00b12c23
m 30000048 00321613
m 3000004c 4021d693
m 30000050 00a1d733
m 30000054 00c12e23
m 30000058 02d12023
m 3000005c 02e12223
m 30000060 12345297
m 30000064 abcde337
m 30000068 02512423
m 3000006c 02612623
m 30000070 00c003ef
m 30000074 02012823
m 30000078 02012823
m 3000007c 02712823
m 30000080 01d384e7
m 30000084 02012a23
m 30000088 02012a23
m 3000008c 02012a23
m 30000090 02912a23
m 30000094 00000793
m 30000098 00179793
m 3000009c 00058463
m 300000a0 00178793
m 300000a4 00179793
m 300000a8 00418463
m 300000ac 00178793
m 300000b0 00179793
m 300000b4 00419463
m 300000b8 00178793
m 300000bc 00179793
m 300000c0 00059463
m 300000c4 00178793
m 300000c8 00179793
m 300000cc 0041c463
m 300000d0 00178793
m 300000d4 00179793
m 300000d8 00324463
m 300000dc 00178793
m 300000e0 00179793
m 300000e4 00325463
m 300000e8 00178793
m 300000ec 00179793
m 300000f0 0041d463
m 300000f4 00178793
m 300000f8 00179793
m 300000fc 00326463
m 30000100 00178793
m 30000104 00179793
m 30000108 0041e463
m 3000010c 00178793
m 30000110 00179793
m 30000114 0041f463
m 30000118 00178793
m 3000011c 00179793
m 30000120 00327463
m 30000124 00178793
m 30000128 02f12c23
m 3000012c 876542b7
m 30000130 32128293
m 30000134 0082d313
m 30000138 0102d393
m 3000013c 0182d413
m 30000140 04510023
m 30000144 046100a3
m 30000148 04710123
m 3000014c 048101a3
m 30000150 04611223
m 30000154 04511323
m 30000158 04314483
m 3000015c 04211503
m 30000160 04215583
m 30000164 04611603
m 30000168 04012683
m 3000016c 04912423
m 30000170 04a12623
m 30000174 04b12823
m 30000178 04c12a23
m 3000017c 04d12c23
m 30000180 0000006f
s 30000400 0000005d f add
s 30000404 ffffff95 f sub
s 30000408 ffffff9d f xor
s 3000040c fffffffd f or
s 30000410 000000f0 f andi
s 30000414 00000001 f slt_neg
s 30000418 00000000 f sltu_neg
s 3000041c 00000320 f slli
s 30000420 fffffffe f srai_neg
s 30000424 7ffffffc f srl
s 30000428 42345060 f auipc
s 3000042c abcde000 f lui
s 30000430 30000074 f jal_link
s 30000434 30000084 f jalr_link
s 30000438 00000555 f branch_paths
s 30000440 00000021 1 sb_lane0
s 30000441 00004300 2 sb_lane1
s 30000442 00650000 4 sb_lane2
s 30000443 87000000 8 sb_lane3
s 30000444 00006543 3 sh_lane0
s 30000446 43210000 c sh_lane2
s 30000448 00000087 f lbu
s 3000044c ffff8765 f lh_neg
s 30000450 00008765 f lhu
s 30000454 00004321 f lh_pos
s 30000458 87654321 f lw

// File: sources.f
hdl/core_pkg.sv
hdl/instr_sequencer.sv
hdl/instr_decoder.sv
hdl/register_file.sv
hdl/execute_unit.sv
hdl/load_store_unit.sv
hdl/writeback_select.sv
hdl/rv_core_top.sv
tb/clock_gen.sv
tb/mem_model.sv
tb/core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module core_tb \
  -f sources.f --Mdir obj_dir -o core_tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "compile failed with status $status"
  exit $status
fi

./obj_dir/core_tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0
